// ==== source/cae_pkg.sv ====
package cae_pkg;

    // Literal and level widths
    localparam int lit_w       = 32;
    localparam int level_w     = 16;

    // Clause slots at the ports and working buffer depth
    localparam int max_lits     = 16;
    localparam int buffer_depth = 32;

    // Count of 32 must fit
    localparam int len_w       = 6;
    localparam int lit_idx_w   = 4;
    localparam int trail_idx_w = 16;
    localparam int clause_id_w = 16;

    // Reason id of a decision variable
    localparam logic [clause_id_w-1:0] no_reason = '1;

    // Controller FSM encodings
    localparam logic [3:0] st_idle   = 4'd0;
    localparam logic [3:0] st_load   = 4'd1;
    localparam logic [3:0] st_count  = 4'd2;
    localparam logic [3:0] st_scan   = 4'd3;
    localparam logic [3:0] st_fetch  = 4'd4;
    localparam logic [3:0] st_length = 4'd5;
    localparam logic [3:0] st_merge  = 4'd6;
    localparam logic [3:0] st_remove = 4'd7;
    localparam logic [3:0] st_final  = 4'd8;
    localparam logic [3:0] st_done   = 4'd9;

    // Variable of a signed literal, i.e. its magnitude
    function automatic logic [lit_w-1:0] lit_var(input logic [lit_w-1:0] lit);
        return lit[lit_w-1] ? -lit : lit;
    endfunction

endpackage

// ==== source/analysis_controller.sv ====
module analysis_controller (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic [cae_pkg::len_w-1:0]         conflict_len,
    input  logic [cae_pkg::trail_idx_w-1:0]   trail_height,
    input  logic [cae_pkg::lit_w-1:0]         trail_read_var,
    input  logic [cae_pkg::clause_id_w-1:0]   trail_read_reason,
    input  logic signed [cae_pkg::lit_w-1:0]  clause_read_literal,
    input  logic [cae_pkg::clause_id_w-1:0]   clause_read_len,
    input  logic [cae_pkg::len_w-1:0]         level_count,
    input  logic                              match_found,
    input  logic [cae_pkg::len_w-1:0]         buf_count,
    output logic                              done,
    output logic                              load,
    output logic                              append_lit,
    output logic                              remove,
    output logic                              finalize,
    output logic [cae_pkg::lit_w-1:0]         match_var,
    output logic [cae_pkg::lit_w-1:0]         resolve_var,
    output logic [cae_pkg::trail_idx_w-1:0]   trail_read_idx,
    output logic [cae_pkg::clause_id_w-1:0]   clause_read_id,
    output logic [cae_pkg::lit_idx_w-1:0]     clause_read_lit_idx,
    output logic [cae_pkg::lit_w-1:0]         level_query_var
);
    import cae_pkg::*;

    logic [3:0]             state;
    logic [trail_idx_w-1:0] scan_ptr;
    // One extra bit so a 16 literal reason can be counted
    logic [lit_idx_w:0]     lit_cnt;
    logic [lit_idx_w:0]     reason_len;
    logic [clause_id_w-1:0] reason_id;
    logic [lit_w-1:0]       clause_var;

    // Strobes decode straight from the state
    assign load     = (state == st_load);
    assign remove   = (state == st_remove);
    assign finalize = (state == st_final);
    assign done     = (state == st_done);

    // Memory addresses
    assign trail_read_idx      = scan_ptr;
    assign clause_read_id      = reason_id;
    assign clause_read_lit_idx = lit_cnt[lit_idx_w-1:0];

    // Trail entry under the pointer is the search key
    assign match_var = trail_read_var;

    // Level lookup for the reason literal being merged
    assign clause_var      = lit_var(clause_read_literal);
    assign level_query_var = clause_var;

    // the resolved variable itself never goes back in
    assign append_lit = (state == st_merge) && (clause_var != resolve_var);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= st_idle;
            scan_ptr   <= '0;
            lit_cnt    <= '0;
            reason_len <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        // Newest trail entry first
                        scan_ptr <= (trail_height != '0) ? trail_height - 1'b1 : '0;
                        state    <= st_load;
                    end
                end
                st_load: begin
                    // Load still pulses so an empty conflict clears the buffer
                    state <= (conflict_len == '0) ? st_final : st_count;
                end
                st_count: begin
                    // Stop at the UIP or on an empty buffer
                    if (buf_count == '0 || level_count <= 1)
                        state <= st_final;
                    else
                        state <= st_scan;
                end
                st_scan: begin
                    if (match_found)
                        state <= st_fetch;
                    else if (scan_ptr == '0)
                        state <= st_final;
                    else
                        scan_ptr <= scan_ptr - 1'b1;
                end
                st_fetch: begin
                    // Decision variable has nothing to resolve with
                    state <= (trail_read_reason == no_reason) ? st_final : st_length;
                end
                st_length: begin
                    lit_cnt <= '0;
                    // Literal index cannot reach past max_lits
                    if (clause_read_len > max_lits)
                        reason_len <= (lit_idx_w + 1)'(max_lits);
                    else
                        reason_len <= clause_read_len[lit_idx_w:0];
                    state <= (clause_read_len == '0) ? st_remove : st_merge;
                end
                st_merge: begin
                    lit_cnt <= lit_cnt + 1'b1;
                    if (lit_cnt + 1'b1 >= reason_len)
                        state <= st_remove;
                end
                st_remove: begin
                    // Resolved entry is consumed so step past it
                    if (scan_ptr != '0)
                        scan_ptr <= scan_ptr - 1'b1;
                    state <= st_count;
                end
                st_final: state <= st_done;
                st_done: begin
                    if (!start)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Resolution operands
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            resolve_var <= '0;
            reason_id   <= '0;
        end else begin
            if (state == st_scan && match_found)
                resolve_var <= trail_read_var;
            if (state == st_fetch)
                reason_id <= trail_read_reason;
        end
    end

endmodule

// ==== source/conflict_buffer.sv ====
module conflict_buffer (
    input  logic                                                        clk,
    input  logic                                                        reset,
    input  logic                                                        load,
    input  logic [cae_pkg::len_w-1:0]                                   conflict_len,
    input  logic signed [cae_pkg::max_lits-1:0][cae_pkg::lit_w-1:0]     conflict_lits,
    input  logic [cae_pkg::max_lits-1:0][cae_pkg::level_w-1:0]          conflict_levels,
    input  logic [cae_pkg::level_w-1:0]                                 decision_level,
    input  logic                                                        append_lit,
    input  logic [cae_pkg::lit_w-1:0]                                   lit_in,
    input  logic [cae_pkg::level_w-1:0]                                 level_in,
    input  logic                                                        remove,
    input  logic [cae_pkg::lit_w-1:0]                                   match_var,
    input  logic [cae_pkg::lit_w-1:0]                                   resolve_var,
    output logic [cae_pkg::len_w-1:0]                                   buf_count,
    output logic [cae_pkg::buffer_depth-1:0][cae_pkg::lit_w-1:0]        buf_lits,
    output logic [cae_pkg::buffer_depth-1:0][cae_pkg::level_w-1:0]      buf_levels,
    output logic [cae_pkg::len_w-1:0]                                   level_count,
    output logic                                                        match_found
);
    import cae_pkg::*;

    logic [buffer_depth-1:0][lit_w-1:0]   lits_nxt;
    logic [buffer_depth-1:0][level_w-1:0] levels_nxt;
    logic [len_w-1:0]                     count_nxt;

    // Load has priority over append and remove
    always_comb begin : update
        int  idx;
        logic dup;
        logic present;
        idx        = 0;
        dup        = 1'b0;
        present    = 1'b0;
        lits_nxt   = buf_lits;
        levels_nxt = buf_levels;
        count_nxt  = buf_count;
        if (load) begin
            // Keep first copy of each exactly repeated literal
            for (int k = 0; k < max_lits; k++) begin
                if (k < conflict_len) begin
                    dup = 1'b0;
                    for (int j = 0; j < k; j++) begin
                        if (conflict_lits[j] == conflict_lits[k])
                            dup = 1'b1;
                    end
                    if (!dup) begin
                        lits_nxt[idx]   = conflict_lits[k];
                        levels_nxt[idx] = conflict_levels[k];
                        idx++;
                    end
                end
            end
            count_nxt = len_w'(idx);
        end else if (append_lit) begin
            // Same variable in either polarity counts as present
            for (int k = 0; k < buffer_depth; k++) begin
                if (k < buf_count && lit_var(buf_lits[k]) == lit_var(lit_in))
                    present = 1'b1;
            end
            // Full buffer drops the literal
            if (!present && buf_count < buffer_depth) begin
                lits_nxt[buf_count]   = lit_in;
                levels_nxt[buf_count] = level_in;
                count_nxt             = buf_count + 1'b1;
            end
        end else if (remove) begin
            // Compact out the resolved variable in order
            for (int k = 0; k < buffer_depth; k++) begin
                if (k < buf_count && lit_var(buf_lits[k]) != resolve_var) begin
                    lits_nxt[idx]   = buf_lits[k];
                    levels_nxt[idx] = buf_levels[k];
                    idx++;
                end
            end
            count_nxt = len_w'(idx);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            buf_count <= '0;
        else
            buf_count <= count_nxt;
    end

    // Literal and level storage
    always_ff @(posedge clk) begin
        buf_lits   <= lits_nxt;
        buf_levels <= levels_nxt;
    end

    // Level count and trail match from registered contents
    always_comb begin : search
        level_count = '0;
        match_found = 1'b0;
        for (int k = 0; k < buffer_depth; k++) begin
            if (k < buf_count && buf_levels[k] == decision_level) begin
                level_count = level_count + 1'b1;
                if (lit_var(buf_lits[k]) == match_var)
                    match_found = 1'b1;
            end
        end
    end

endmodule

// ==== source/learned_clause_builder.sv ====
module learned_clause_builder (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic                                                    finalize,
    input  logic                                                    start,
    input  logic [cae_pkg::len_w-1:0]                               buf_count,
    input  logic [cae_pkg::buffer_depth-1:0][cae_pkg::lit_w-1:0]    buf_lits,
    input  logic [cae_pkg::buffer_depth-1:0][cae_pkg::level_w-1:0]  buf_levels,
    input  logic [cae_pkg::level_w-1:0]                             decision_level,
    output logic                                                    learned_valid,
    output logic [cae_pkg::len_w-1:0]                               learned_len,
    output logic signed [cae_pkg::max_lits-1:0][cae_pkg::lit_w-1:0] learned_clause,
    output logic [cae_pkg::level_w-1:0]                             backtrack_level,
    output logic                                                    unsat
);
    import cae_pkg::*;

    logic [level_w-1:0]               max_lvl;
    logic [level_w-1:0]               second_lvl;
    logic [max_lits-1:0][lit_w-1:0]   clause_nxt;
    logic [len_w-1:0]                 len_nxt;
    logic                             start_q;

    always_comb begin : build
        logic [buffer_depth-1:0] live;
        logic uip_seen;
        int   out_idx;
        live       = '0;
        uip_seen   = 1'b0;
        out_idx    = 1;
        max_lvl    = '0;
        second_lvl = '0;
        clause_nxt = '0;
        // Occupied slots with a real variable
        for (int k = 0; k < buffer_depth; k++) begin
            live[k] = (k < buf_count) && (lit_var(buf_lits[k]) != '0);
            if (live[k] && buf_levels[k] > max_lvl)
                max_lvl = buf_levels[k];
        end
        // Backtrack target is the highest level below the max
        for (int k = 0; k < buffer_depth; k++) begin
            if (live[k] && buf_levels[k] != max_lvl && buf_levels[k] > second_lvl)
                second_lvl = buf_levels[k];
        end
        // UIP into slot zero, rest in buffer order up to max_lits
        for (int k = 0; k < buffer_depth; k++) begin
            if (live[k]) begin
                if (!uip_seen && buf_levels[k] == max_lvl) begin
                    clause_nxt[0] = buf_lits[k];
                    uip_seen      = 1'b1;
                end else if (out_idx < max_lits) begin
                    clause_nxt[out_idx] = buf_lits[k];
                    out_idx++;
                end
            end
        end
        len_nxt = uip_seen ? len_w'(out_idx) : '0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_q         <= 1'b0;
            learned_valid   <= 1'b0;
            learned_len     <= '0;
            learned_clause  <= '0;
            backtrack_level <= '0;
            unsat           <= 1'b0;
        end else begin
            start_q <= start;
            if (finalize) begin
                learned_valid   <= 1'b1;
                learned_len     <= len_nxt;
                learned_clause  <= clause_nxt;
                backtrack_level <= second_lvl;
                // Empty clause or root level conflict
                unsat           <= (buf_count == '0) || (decision_level == '0);
            end else if (start && !start_q) begin
                // new analysis starting
                learned_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== source/cae_top.sv ====
module cae_top (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic                                                    start,
    input  logic [cae_pkg::level_w-1:0]                             decision_level,
    input  logic [cae_pkg::len_w-1:0]                               conflict_len,
    input  logic signed [cae_pkg::max_lits-1:0][cae_pkg::lit_w-1:0] conflict_lits,
    input  logic [cae_pkg::max_lits-1:0][cae_pkg::level_w-1:0]      conflict_levels,
    input  logic [cae_pkg::lit_w-1:0]                               trail_read_var,
    input  logic [cae_pkg::clause_id_w-1:0]                         trail_read_reason,
    input  logic [cae_pkg::trail_idx_w-1:0]                         trail_height,
    input  logic signed [cae_pkg::lit_w-1:0]                        clause_read_literal,
    input  logic [cae_pkg::clause_id_w-1:0]                         clause_read_len,
    input  logic [cae_pkg::level_w-1:0]                             level_query_level,
    output logic                                                    learned_valid,
    output logic [cae_pkg::len_w-1:0]                               learned_len,
    output logic signed [cae_pkg::max_lits-1:0][cae_pkg::lit_w-1:0] learned_clause,
    output logic [cae_pkg::level_w-1:0]                             backtrack_level,
    output logic                                                    unsat,
    output logic                                                    done,
    output logic [cae_pkg::trail_idx_w-1:0]                         trail_read_idx,
    output logic [cae_pkg::clause_id_w-1:0]                         clause_read_id,
    output logic [cae_pkg::lit_idx_w-1:0]                           clause_read_lit_idx,
    output logic [cae_pkg::lit_w-1:0]                               level_query_var
);
    import cae_pkg::*;

    // Controller strobes into the buffer
    logic load;
    logic append_lit;
    logic remove;
    logic finalize;
    logic [lit_w-1:0] match_var;
    logic [lit_w-1:0] resolve_var;

    // Buffer state seen by controller and builder
    logic [len_w-1:0]                       buf_count;
    logic [buffer_depth-1:0][lit_w-1:0]     buf_lits;
    logic [buffer_depth-1:0][level_w-1:0]   buf_levels;
    logic [len_w-1:0]                       level_count;
    logic match_found;

    analysis_controller analysis_controller_inst (
        .clk                 (clk),
        .reset               (reset),
        .start               (start),
        .conflict_len        (conflict_len),
        .trail_height        (trail_height),
        .trail_read_var      (trail_read_var),
        .trail_read_reason   (trail_read_reason),
        .clause_read_literal (clause_read_literal),
        .clause_read_len     (clause_read_len),
        .level_count         (level_count),
        .match_found         (match_found),
        .buf_count           (buf_count),
        .done                (done),
        .load                (load),
        .append_lit          (append_lit),
        .remove              (remove),
        .finalize            (finalize),
        .match_var           (match_var),
        .resolve_var         (resolve_var),
        .trail_read_idx      (trail_read_idx),
        .clause_read_id      (clause_read_id),
        .clause_read_lit_idx (clause_read_lit_idx),
        .level_query_var     (level_query_var)
    );

    // Reason literal and its level come straight from the memories
    conflict_buffer conflict_buffer_inst (
        .clk             (clk),
        .reset           (reset),
        .load            (load),
        .conflict_len    (conflict_len),
        .conflict_lits   (conflict_lits),
        .conflict_levels (conflict_levels),
        .decision_level  (decision_level),
        .append_lit      (append_lit),
        .lit_in          (clause_read_literal),
        .level_in        (level_query_level),
        .remove          (remove),
        .match_var       (match_var),
        .resolve_var     (resolve_var),
        .buf_count       (buf_count),
        .buf_lits        (buf_lits),
        .buf_levels      (buf_levels),
        .level_count     (level_count),
        .match_found     (match_found)
    );

    learned_clause_builder learned_clause_builder_inst (
        .clk             (clk),
        .reset           (reset),
        .finalize        (finalize),
        .start           (start),
        .buf_count       (buf_count),
        .buf_lits        (buf_lits),
        .buf_levels      (buf_levels),
        .decision_level  (decision_level),
        .learned_valid   (learned_valid),
        .learned_len     (learned_len),
        .learned_clause  (learned_clause),
        .backtrack_level (backtrack_level),
        .unsat           (unsat)
    );

endmodule

// ==== verif/cae_model.svh ====
`ifndef cae_model_svh
`define cae_model_svh

    // Expected results of the current scenario
    logic [lit_w-1:0] exp_clause [max_lits];
    int   exp_len;
    int   exp_bt;
    logic exp_unsat;

    // First-UIP resolution over the scenario trail, clause and level memories
    task automatic run_model();
        int   blit [buffer_depth];
        int   blev [buffer_depth];
        int   bcnt;
        int   ptr;
        int   rv;
        int   rid;
        int   n;
        int   v;
        int   lc;
        int   top;
        int   keep;
        logic found;
        logic stop;
        bcnt = 0;
        // Copy the conflict, exact repeats dropped
        for (int k = 0; k < conflict_len; k++) begin
            found = 1'b0;
            for (int j = 0; j < k; j++) begin
                if (conflict_lits[j] == conflict_lits[k])
                    found = 1'b1;
            end
            if (!found) begin
                blit[bcnt] = int'(conflict_lits[k]);
                blev[bcnt] = conflict_levels[k];
                bcnt++;
            end
        end
        ptr  = (trail_len > 0) ? trail_len - 1 : 0;
        stop = (conflict_len == 0);
        while (!stop) begin
            lc = 0;
            for (int k = 0; k < bcnt; k++) begin
                if (blev[k] == decision_level)
                    lc++;
            end
            if (bcnt == 0 || lc <= 1)
                break;
            // Newest trail entry whose variable sits in the buffer at the current level
            found = 1'b0;
            while (!found && !stop) begin
                for (int k = 0; k < bcnt; k++) begin
                    if (blev[k] == decision_level && magnitude(blit[k]) == trail_var[ptr])
                        found = 1'b1;
                end
                if (!found) begin
                    if (ptr == 0)
                        stop = 1'b1;
                    else
                        ptr--;
                end
            end
            // Bottom of the trail or a decision ends the walk
            if (stop || trail_reason[ptr] == no_reason)
                break;
            rv  = trail_var[ptr];
            rid = trail_reason[ptr];
            n   = (clause_len_mem[rid] > max_lits) ? max_lits : clause_len_mem[rid];
            for (int i = 0; i < n; i++) begin
                v     = magnitude(clause_mem[rid][i]);
                found = 1'b0;
                for (int k = 0; k < bcnt; k++) begin
                    if (magnitude(blit[k]) == v)
                        found = 1'b1;
                end
                // New variables only, full buffer drops the rest
                if (v != rv && !found && bcnt < buffer_depth) begin
                    blit[bcnt] = clause_mem[rid][i];
                    blev[bcnt] = lvl_tab[v];
                    bcnt++;
                end
            end
            keep = 0;
            for (int k = 0; k < bcnt; k++) begin
                if (magnitude(blit[k]) != rv) begin
                    blit[keep] = blit[k];
                    blev[keep] = blev[k];
                    keep++;
                end
            end
            bcnt = keep;
            if (ptr != 0)
                ptr--;
        end
        // Highest and second highest level among real variables
        top    = 0;
        exp_bt = 0;
        for (int k = 0; k < bcnt; k++) begin
            if (magnitude(blit[k]) != 0 && blev[k] > top)
                top = blev[k];
        end
        for (int k = 0; k < bcnt; k++) begin
            if (magnitude(blit[k]) != 0 && blev[k] != top && blev[k] > exp_bt)
                exp_bt = blev[k];
        end
        // UIP first, others in buffer order, cut at max_lits
        for (int k = 0; k < max_lits; k++)
            exp_clause[k] = '0;
        n     = 1;
        found = 1'b0;
        for (int k = 0; k < bcnt; k++) begin
            if (magnitude(blit[k]) != 0) begin
                if (!found && blev[k] == top) begin
                    exp_clause[0] = blit[k];
                    found         = 1'b1;
                end else if (n < max_lits) begin
                    exp_clause[n] = blit[k];
                    n++;
                end
            end
        end
        exp_len   = found ? n : 0;
        exp_unsat = (bcnt == 0) || (decision_level == 0);
    endtask

`endif

// ==== verif/tb_cae.sv ====
module tb_cae;
    timeunit 1ns;
    timeprecision 1ps;
    import cae_pkg::*;

    localparam int num_tests   = 200;
    localparam int cycle_limit = num_tests * (12 * 20 + 40);

    logic clk;
    logic reset;
    logic start;
    logic [level_w-1:0] decision_level;
    logic [len_w-1:0] conflict_len;
    logic signed [max_lits-1:0][lit_w-1:0] conflict_lits;
    logic [max_lits-1:0][level_w-1:0] conflict_levels;
    logic [lit_w-1:0] trail_read_var;
    logic [clause_id_w-1:0] trail_read_reason;
    logic [trail_idx_w-1:0] trail_height;
    logic signed [lit_w-1:0] clause_read_literal;
    logic [clause_id_w-1:0] clause_read_len;
    logic [level_w-1:0] level_query_level;
    logic learned_valid;
    logic [len_w-1:0] learned_len;
    logic signed [max_lits-1:0][lit_w-1:0] learned_clause;
    logic [level_w-1:0] backtrack_level;
    logic unsat;
    logic done;
    logic [trail_idx_w-1:0] trail_read_idx;
    logic [clause_id_w-1:0] clause_read_id;
    logic [lit_idx_w-1:0] clause_read_lit_idx;
    logic [lit_w-1:0] level_query_var;

    // Reason id of an implied entry is its trail index
    int trail_var [16];
    logic [clause_id_w-1:0] trail_reason [16];
    int trail_len;
    int clause_mem [16][16];
    int clause_len_mem [16];
    int lvl_tab [64];

    int errors;
    int checks;
    int cycles;

    function automatic int magnitude(input int lit);
        return (lit < 0) ? -lit : lit;
    endfunction

    function automatic int random_polarity(input int v);
        return ($urandom_range(0, 1) == 1) ? -v : v;
    endfunction

    `include "cae_model.svh"

    cae_top cae_top_inst (.*);

    // Memories answer in the same cycle
    assign trail_height        = trail_idx_w'(trail_len);
    assign trail_read_var      = (trail_read_idx < 16) ? trail_var[trail_read_idx[3:0]] : '0;
    assign trail_read_reason   = (trail_read_idx < 16) ? trail_reason[trail_read_idx[3:0]] : '1;
    assign clause_read_literal = (clause_read_id < 16) ?
                                 clause_mem[clause_read_id[3:0]][clause_read_lit_idx] : '0;
    assign clause_read_len     = (clause_read_id < 16) ?
                                 clause_id_w'(clause_len_mem[clause_read_id[3:0]]) : '0;
    assign level_query_level   = (level_query_var < 64) ?
                                 level_w'(lvl_tab[level_query_var[5:0]]) : '0;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Run limit from the worst case length of one scenario
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: engine did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
        end
    endtask

    // Trail with non-decreasing levels, reasons and a conflict over it
    task automatic gen_scenario();
        int lvl;
        int v;
        int lit;
        int pick;
        bit used [64];
        lvl = 0;
        for (int i = 0; i < 64; i++) begin
            used[i]    = 1'b0;
            lvl_tab[i] = 0;
        end
        for (int i = 0; i < 16; i++) begin
            trail_var[i]      = 0;
            trail_reason[i]   = no_reason;
            clause_len_mem[i] = 0;
            for (int k = 0; k < 16; k++)
                clause_mem[i][k] = 0;
        end
        trail_len = $urandom_range(4, 12);
        for (int i = 0; i < trail_len; i++) begin
            do
                v = $urandom_range(1, 40);
            while (used[v]);
            used[v]      = 1'b1;
            trail_var[i] = v;
            if (i == 0 || $urandom_range(0, 2) == 0) begin
                lvl++;
            end else begin
                // Reason of an implied entry holds it plus older trail or off-trail vars
                trail_reason[i]   = clause_id_w'(i);
                clause_len_mem[i] = $urandom_range(1, 20);
                clause_mem[i][0]  = random_polarity(v);
                for (int k = 1; k < 16; k++) begin
                    if ($urandom_range(0, 1) == 0)
                        clause_mem[i][k] = random_polarity(trail_var[$urandom_range(0, i - 1)]);
                    else
                        clause_mem[i][k] = random_polarity($urandom_range(41, 63));
                end
            end
            lvl_tab[v] = lvl;
        end
        // Off-trail vars fill the buffer
        for (int e = 41; e < 64; e++)
            lvl_tab[e] = $urandom_range(0, lvl);
        decision_level  = ($urandom_range(0, 9) == 0) ? '0 : level_w'(lvl);
        conflict_len    = ($urandom_range(0, 9) == 0) ? '0 : len_w'($urandom_range(1, max_lits));
        conflict_lits   = '0;
        conflict_levels = '0;
        for (int k = 0; k < conflict_len; k++) begin
            pick = $urandom_range(0, 19);
            if (pick == 0)
                lit = 0;
            else if (pick < 4 && k > 0)
                lit = int'(conflict_lits[$urandom_range(0, k - 1)]);
            else if (pick < 12)
                lit = random_polarity(trail_var[$urandom_range(trail_len / 2, trail_len - 1)]);
            else
                lit = random_polarity(trail_var[$urandom_range(0, trail_len - 1)]);
            conflict_lits[k]   = lit;
            conflict_levels[k] = level_w'(lvl_tab[magnitude(lit)]);
        end
    endtask

    initial begin
        int hold;
        int errs_before;
        errors          = 0;
        checks          = 0;
        cycles          = 0;
        reset           = 1'b1;
        start           = 1'b0;
        decision_level  = '0;
        conflict_len    = '0;
        conflict_lits   = '0;
        conflict_levels = '0;
        trail_len       = 0;
        for (int i = 0; i < 16; i++)
            trail_reason[i] = no_reason;
        void'($urandom(42));
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        check("done", done, 0);
        check("learned_valid", learned_valid, 0);
        check("unsat", unsat, 0);
        check("backtrack_level", backtrack_level, 0);
        check("learned_len", learned_len, 0);
        for (int k = 0; k < max_lits; k++)
            check($sformatf("learned_clause[%0d]", k), learned_clause[k], 0);
        $display("test 0 reset values: %s", (errors == 0) ? "ok" : "mismatch");
        for (int t = 1; t <= num_tests; t++) begin
            errs_before = errors;
            gen_scenario();
            run_model();
            start = 1'b1;
            @(posedge clk);
            #1;
            // Previous result withdrawn as the new analysis starts
            if (t > 1)
                check("learned_valid", learned_valid, 0);
            while (!done) begin
                @(posedge clk);
                #1;
            end
            check("unsat", unsat, exp_unsat);
            check("learned_len", learned_len, exp_len);
            check("backtrack_level", backtrack_level, exp_bt);
            for (int k = 0; k < max_lits; k++)
                check($sformatf("learned_clause[%0d]", k), learned_clause[k], exp_clause[k]);
            check("learned_valid", learned_valid, 1);
            // done held as long as start
            hold = $urandom_range(0, 3);
            repeat (hold) begin
                @(posedge clk);
                #1;
                check("done", done, 1);
            end
            start = 1'b0;
            @(posedge clk);
            #1;
            check("done", done, 0);
            check("learned_valid", learned_valid, 1);
            $display("test %0d: dl=%0d conflict_len=%0d learned_len=%0d unsat=%0b %s",
                     t, decision_level, conflict_len, learned_len, unsat,
                     (errors == errs_before) ? "ok" : "mismatch");
        end
        $display("tests=%0d checks=%0d errors=%0d", num_tests + 1, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+verif
source/cae_pkg.sv
source/analysis_controller.sv
source/conflict_buffer.sv
source/learned_clause_builder.sv
source/cae_top.sv
verif/tb_cae.sv
